//--- src/axi_pkg.sv
`default_nettype none

package axi_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [1:0]        resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // master to slave
    typedef struct packed {
        addr_t awaddr;
        logic  awvalid;
        data_t wdata;
        strb_t wstrb;
        logic  wvalid;
        logic  bready;
        addr_t araddr;
        logic  arvalid;
        logic  rready;
    } axi_req_t;

    // slave to master
    typedef struct packed {
        logic  awready;
        logic  wready;
        resp_t bresp;
        logic  bvalid;
        logic  arready;
        data_t rdata;
        resp_t rresp;
        logic  rvalid;
    } axi_resp_t;

endpackage

`default_nettype wire

//--- src/soc_pkg.sv
`default_nettype none

package soc_pkg;
    import axi_pkg::*;

    // memory map
    localparam addr_t SRAM_BASE   = 32'h1000_0000;
    localparam int    SRAM_WIN_W  = 16;     // 64 KiB
    localparam addr_t SYSIO_BASE  = 32'h2000_0000;
    localparam int    SYSIO_WIN_W = 12;     // 4 KiB

    typedef logic [SYSIO_WIN_W-1:0] io_ofs_t;

    localparam io_ofs_t GPIO_OUT_OFS = 12'h000;
    localparam io_ofs_t GPIO_OE_OFS  = 12'h004;
    localparam io_ofs_t GPIO_IN_OFS  = 12'h008;   // read only

    typedef enum logic [1:0] {
        SEL_SRAM,
        SEL_SYSIO,
        SEL_NONE
    } slave_sel_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WRITE,
        ARB_READ
    } arb_state_t;

endpackage

`default_nettype wire

//--- src/axi_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module axi_arbiter
    import axi_pkg::*;
    import soc_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire axi_req_t  m0_req,
    output axi_resp_t      m0_resp,
    input  wire axi_req_t  m1_req,
    output axi_resp_t      m1_resp,
    output axi_req_t       bus_req,
    input  wire axi_resp_t bus_resp
);

    arb_state_t state;
    logic       grant;      // 0 = m0, 1 = m1
    logic       last;       // master served last
    logic       wr0, wr1;
    logic       any0, any1;
    logic       pick;
    logic       done;
    axi_req_t   gnt_req;

    assign wr0  = m0_req.awvalid & m0_req.wvalid;
    assign wr1  = m1_req.awvalid & m1_req.wvalid;
    assign any0 = wr0 | m0_req.arvalid;
    assign any1 = wr1 | m1_req.arvalid;
    assign pick = (any0 && any1) ? ~last : any1;

    assign gnt_req = grant ? m1_req : m0_req;

    assign done = (state == ARB_WRITE && bus_resp.bvalid && gnt_req.bready) ||
                  (state == ARB_READ  && bus_resp.rvalid && gnt_req.rready);

    //******************************************************************
    // grant FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            grant <= 1'b0;
            last  <= 1'b1;      // m0 first out of reset
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (any0 || any1) begin
                        grant <= pick;
                        last  <= pick;
                        state <= (pick ? wr1 : wr0) ? ARB_WRITE : ARB_READ;
                    end
                end
                default: begin
                    if (done)
                        state <= ARB_IDLE;
                end
            endcase
        end
    end

    //******************************************************************
    // forward only the channel that was granted
    always_comb begin
        bus_req = '0;
        if (state == ARB_WRITE) begin
            bus_req.awaddr  = gnt_req.awaddr;
            bus_req.awvalid = gnt_req.awvalid;
            bus_req.wdata   = gnt_req.wdata;
            bus_req.wstrb   = gnt_req.wstrb;
            bus_req.wvalid  = gnt_req.wvalid;
            bus_req.bready  = gnt_req.bready;
        end else if (state == ARB_READ) begin
            bus_req.araddr  = gnt_req.araddr;
            bus_req.arvalid = gnt_req.arvalid;
            bus_req.rready  = gnt_req.rready;
        end
    end

    always_comb begin
        m0_resp = '0;
        m1_resp = '0;
        if (state != ARB_IDLE) begin
            if (grant)
                m1_resp = bus_resp;
            else
                m0_resp = bus_resp;
        end
    end

endmodule

`default_nettype wire

//--- src/axi_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module axi_decoder
    import axi_pkg::*;
    import soc_pkg::*;
#(
    parameter int SRAM_DEPTH = 1024
) (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire axi_req_t  bus_req,
    output axi_resp_t      bus_resp,
    output axi_req_t       sram_req,
    input  wire axi_resp_t sram_resp,
    output axi_req_t       sysio_req,
    input  wire axi_resp_t sysio_resp
);

    slave_sel_t sel_d, sel_q, sel;
    logic       busy;
    logic       err_b, err_r;
    logic       accept, done;
    addr_t      addr;
    axi_resp_t  err_resp;

    assign addr = bus_req.awvalid ? bus_req.awaddr : bus_req.araddr;

    always_comb begin
        if (addr[ADDR_W-1:SRAM_WIN_W] == SRAM_BASE[ADDR_W-1:SRAM_WIN_W] &&
            32'(addr[SRAM_WIN_W-1:2]) < 32'(SRAM_DEPTH))
            sel_d = SEL_SRAM;
        else if (addr[ADDR_W-1:SYSIO_WIN_W] == SYSIO_BASE[ADDR_W-1:SYSIO_WIN_W])
            sel_d = SEL_SYSIO;
        else
            sel_d = SEL_NONE;
    end

    assign sel = busy ? sel_q : sel_d;  // held until response done

    // unmapped addresses are answered here
    always_comb begin
        err_resp         = '0;
        err_resp.awready = !busy && bus_req.awvalid && bus_req.wvalid;
        err_resp.wready  = !busy && bus_req.awvalid && bus_req.wvalid;
        err_resp.arready = !busy && bus_req.arvalid;
        err_resp.bresp   = RESP_SLVERR;
        err_resp.bvalid  = err_b;
        err_resp.rresp   = RESP_SLVERR;
        err_resp.rvalid  = err_r;
    end

    always_comb begin
        sram_req  = (sel == SEL_SRAM)  ? bus_req : '0;
        sysio_req = (sel == SEL_SYSIO) ? bus_req : '0;
        case (sel)
            SEL_SRAM:  bus_resp = sram_resp;
            SEL_SYSIO: bus_resp = sysio_resp;
            default:   bus_resp = err_resp;
        endcase
    end

    assign accept = !busy && ((bus_req.awvalid && bus_resp.awready) ||
                              (bus_req.arvalid && bus_resp.arready));
    assign done   = (bus_resp.bvalid && bus_req.bready) ||
                    (bus_resp.rvalid && bus_req.rready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            sel_q <= SEL_NONE;
            err_b <= 1'b0;
            err_r <= 1'b0;
        end else begin
            if (accept) begin
                busy  <= 1'b1;
                sel_q <= sel_d;
                err_b <= (sel_d == SEL_NONE) && bus_req.awvalid;
                err_r <= (sel_d == SEL_NONE) && !bus_req.awvalid;
            end else if (done) begin
                busy  <= 1'b0;
                err_b <= 1'b0;
                err_r <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/sram.sv
`timescale 1ns/10ps
`default_nettype none

module sram
    import axi_pkg::*;
#(
    parameter int SRAM_DEPTH = 1024
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire axi_req_t sram_req,
    output axi_resp_t     sram_resp
);

    localparam int IDX_W = $clog2(SRAM_DEPTH);

    data_t            mem [SRAM_DEPTH];
    data_t            rdata_q;
    logic             bvalid_q, rvalid_q;
    logic             idle, wr_go, rd_go;
    logic [IDX_W-1:0] widx, ridx;

    assign idle  = !bvalid_q && !rvalid_q;
    assign wr_go = idle && sram_req.awvalid && sram_req.wvalid;
    assign rd_go = idle && sram_req.arvalid && !wr_go;
    assign widx  = sram_req.awaddr[IDX_W+1:2];   // word index
    assign ridx  = sram_req.araddr[IDX_W+1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_go)
                bvalid_q <= 1'b1;
            else if (sram_req.bready)
                bvalid_q <= 1'b0;
            if (rd_go)
                rvalid_q <= 1'b1;
            else if (sram_req.rready)
                rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < STRB_W; b++) begin
            if (wr_go && sram_req.wstrb[b])
                mem[widx][8*b +: 8] <= sram_req.wdata[8*b +: 8];
        end
        if (rd_go)
            rdata_q <= mem[ridx];
    end

    always_comb begin
        sram_resp         = '0;
        sram_resp.awready = wr_go;
        sram_resp.wready  = wr_go;
        sram_resp.bresp   = RESP_OKAY;
        sram_resp.bvalid  = bvalid_q;
        sram_resp.arready = rd_go;
        sram_resp.rdata   = rdata_q;
        sram_resp.rresp   = RESP_OKAY;
        sram_resp.rvalid  = rvalid_q;
    end

endmodule

`default_nettype wire

//--- src/sysio.sv
`timescale 1ns/10ps
`default_nettype none

module sysio
    import axi_pkg::*;
    import soc_pkg::*;
#(
    parameter int GPIO_W = 32
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire axi_req_t          sysio_req,
    output axi_resp_t              sysio_resp,
    input  wire logic [GPIO_W-1:0] gpio_i,
    output logic [GPIO_W-1:0]      gpio_o,
    output logic [GPIO_W-1:0]      gpio_oe
);

    logic [GPIO_W-1:0] out_q, oe_q, in_q;
    logic              bvalid_q, rvalid_q;
    logic              idle, wr_go, rd_go;
    io_ofs_t           wofs, rofs;
    data_t             out_new, oe_new, rdata_d, rdata_q;

    function automatic data_t merge(data_t old, data_t wd, strb_t st);
        data_t res;
        res = old;
        for (int b = 0; b < STRB_W; b++) begin
            if (st[b])
                res[8*b +: 8] = wd[8*b +: 8];
        end
        return res;
    endfunction

    assign idle    = !bvalid_q && !rvalid_q;
    assign wr_go   = idle && sysio_req.awvalid && sysio_req.wvalid;
    assign rd_go   = idle && sysio_req.arvalid && !wr_go;
    assign wofs    = sysio_req.awaddr[SYSIO_WIN_W-1:0];
    assign rofs    = sysio_req.araddr[SYSIO_WIN_W-1:0];
    assign out_new = merge(data_t'(out_q), sysio_req.wdata, sysio_req.wstrb);
    assign oe_new  = merge(data_t'(oe_q), sysio_req.wdata, sysio_req.wstrb);

    always_comb begin
        case (rofs)
            GPIO_OUT_OFS: rdata_d = data_t'(out_q);
            GPIO_OE_OFS:  rdata_d = data_t'(oe_q);
            GPIO_IN_OFS:  rdata_d = data_t'(in_q);
            default:      rdata_d = '0;    // unused offsets
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_q    <= '0;
            oe_q     <= '0;
            in_q     <= '0;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            in_q <= gpio_i;     // one sync stage
            if (wr_go && wofs == GPIO_OUT_OFS)
                out_q <= out_new[GPIO_W-1:0];
            if (wr_go && wofs == GPIO_OE_OFS)
                oe_q <= oe_new[GPIO_W-1:0];
            if (wr_go)
                bvalid_q <= 1'b1;
            else if (sysio_req.bready)
                bvalid_q <= 1'b0;
            if (rd_go)
                rvalid_q <= 1'b1;
            else if (sysio_req.rready)
                rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go)
            rdata_q <= rdata_d;
    end

    always_comb begin
        sysio_resp         = '0;
        sysio_resp.awready = wr_go;
        sysio_resp.wready  = wr_go;
        sysio_resp.bresp   = RESP_OKAY;
        sysio_resp.bvalid  = bvalid_q;
        sysio_resp.arready = rd_go;
        sysio_resp.rdata   = rdata_q;
        sysio_resp.rresp   = RESP_OKAY;
        sysio_resp.rvalid  = rvalid_q;
    end

    assign gpio_o  = out_q;
    assign gpio_oe = oe_q;

endmodule

`default_nettype wire

//--- src/soc_top.sv
`timescale 1ns/10ps
`default_nettype none

module soc_top
    import axi_pkg::*;
#(
    parameter int SRAM_DEPTH = 1024,
    parameter int GPIO_W     = 32
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire axi_req_t          m0_req,     // debug port
    output axi_resp_t              m0_resp,
    input  wire axi_req_t          m1_req,     // core port
    output axi_resp_t              m1_resp,
    input  wire logic [GPIO_W-1:0] gpio_i,
    output logic [GPIO_W-1:0]      gpio_o,
    output logic [GPIO_W-1:0]      gpio_oe
);

    axi_req_t  bus_req, sram_req, sysio_req;
    axi_resp_t bus_resp, sram_resp, sysio_resp;

    //******************************************************************
    // interconnect
    axi_arbiter u_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .m0_req   (m0_req),
        .m0_resp  (m0_resp),
        .m1_req   (m1_req),
        .m1_resp  (m1_resp),
        .bus_req  (bus_req),
        .bus_resp (bus_resp)
    );

    axi_decoder #(.SRAM_DEPTH(SRAM_DEPTH)) u_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_req    (bus_req),
        .bus_resp   (bus_resp),
        .sram_req   (sram_req),
        .sram_resp  (sram_resp),
        .sysio_req  (sysio_req),
        .sysio_resp (sysio_resp)
    );

    //******************************************************************
    // slaves
    sram #(.SRAM_DEPTH(SRAM_DEPTH)) u_sram (
        .clk       (clk),
        .rst_n     (rst_n),
        .sram_req  (sram_req),
        .sram_resp (sram_resp)
    );

    sysio #(.GPIO_W(GPIO_W)) u_sysio (
        .clk        (clk),
        .rst_n      (rst_n),
        .sysio_req  (sysio_req),
        .sysio_resp (sysio_resp),
        .gpio_i     (gpio_i),
        .gpio_o     (gpio_o),
        .gpio_oe    (gpio_oe)
    );

endmodule

`default_nettype wire

//--- testbench/soc_sva.sv
`timescale 1ns/10ps
`default_nettype none

module soc_sva
    import axi_pkg::*;
(
    input wire logic      clk,
    input wire logic      rst_n,
    input wire axi_req_t  m0_req,
    input wire axi_resp_t m0_resp,
    input wire axi_req_t  m1_req,
    input wire axi_resp_t m1_resp
);

    logic act0, act1;
    logic acc0, acc1;
    logic fin0, fin1;
    logic pend0, pend1;     // accepted, response not yet taken

    assign act0 = m0_resp.awready || m0_resp.wready || m0_resp.arready ||
                  m0_resp.bvalid || m0_resp.rvalid;
    assign act1 = m1_resp.awready || m1_resp.wready || m1_resp.arready ||
                  m1_resp.bvalid || m1_resp.rvalid;

    assign acc0 = (m0_req.awvalid && m0_resp.awready) || (m0_req.arvalid && m0_resp.arready);
    assign acc1 = (m1_req.awvalid && m1_resp.awready) || (m1_req.arvalid && m1_resp.arready);
    assign fin0 = (m0_resp.bvalid && m0_req.bready) || (m0_resp.rvalid && m0_req.rready);
    assign fin1 = (m1_resp.bvalid && m1_req.bready) || (m1_resp.rvalid && m1_req.rready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend0 <= 1'b0;
            pend1 <= 1'b0;
        end else begin
            if (acc0)
                pend0 <= 1'b1;
            else if (fin0)
                pend0 <= 1'b0;
            if (acc1)
                pend1 <= 1'b1;
            else if (fin1)
                pend1 <= 1'b0;
        end
    end

    //******************************************************************
    // arbiter handshake properties
    a_one_master: assert property (@(posedge clk) disable iff (!rst_n)
        !(act0 && pend1) && !(act1 && pend0))
        else $error("arbiter serves one master while the other has a transaction open");

    a_b0_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m0_resp.bvalid && !m0_req.bready |=> m0_resp.bvalid && $stable(m0_resp.bresp))
        else $error("m0 bvalid or bresp changed before bready");
    a_b1_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m1_resp.bvalid && !m1_req.bready |=> m1_resp.bvalid && $stable(m1_resp.bresp))
        else $error("m1 bvalid or bresp changed before bready");
    a_r0_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m0_resp.rvalid && !m0_req.rready |=> m0_resp.rvalid && $stable(m0_resp.rdata))
        else $error("m0 rvalid or rdata changed before rready");
    a_r1_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m1_resp.rvalid && !m1_req.rready |=> m1_resp.rvalid && $stable(m1_resp.rdata))
        else $error("m1 rvalid or rdata changed before rready");

    // response only to a master with an accepted request
    a_m0_pending: assert property (@(posedge clk) disable iff (!rst_n)
        m0_resp.bvalid || m0_resp.rvalid |-> pend0)
        else $error("m0 got a response with no request pending");
    a_m1_pending: assert property (@(posedge clk) disable iff (!rst_n)
        m1_resp.bvalid || m1_resp.rvalid |-> pend1)
        else $error("m1 got a response with no request pending");

endmodule

bind axi_arbiter soc_sva soc_sva_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .m0_req  (m0_req),
    .m0_resp (m0_resp),
    .m1_req  (m1_req),
    .m1_resp (m1_resp)
);

`default_nettype wire

//--- testbench/soc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module soc_tb
    import axi_pkg::*;
    import soc_pkg::*;
();

    localparam int SRAM_DEPTH = 1024;
    localparam int GPIO_W     = 32;
    localparam int TIMEOUT    = 100;    // cycles per wait

    typedef struct packed {
        resp_t resp;
        data_t data;
    } rd_exp_t;

    logic              clk;
    logic              rst_n;
    axi_req_t          m0_req, m1_req;
    axi_resp_t         m0_resp, m1_resp;
    logic [GPIO_W-1:0] gpio_i, gpio_o, gpio_oe;

    // shadow model
    data_t sram_mdl [SRAM_DEPTH];
    bit    was_written [SRAM_DEPTH];
    data_t out_mdl, oe_mdl, in_mdl;

    string name_q [$];
    data_t exp_q [$];
    data_t act_q [$];

    string cur_test;
    int    test_err0;
    int    n_tests, n_failed, n_checks, n_errors;
    int    cyc;
    int    done_cnt [2];
    int    acc_cyc [2];
    int    done_cyc [2];

    soc_top #(
        .SRAM_DEPTH (SRAM_DEPTH),
        .GPIO_W     (GPIO_W)
    ) soc_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .m0_req  (m0_req),
        .m0_resp (m0_resp),
        .m1_req  (m1_req),
        .m1_resp (m1_resp),
        .gpio_i  (gpio_i),
        .gpio_o  (gpio_o),
        .gpio_oe (gpio_oe)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    //******************************************************************
    // reference model
    function automatic data_t apply_strobes(data_t old, data_t wd, strb_t st);
        data_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (st[b])
                res[8*b +: 8] = wd[8*b +: 8];
        end
        return res;
    endfunction

    function automatic int sram_index(addr_t a);
        if (a[31:16] != SRAM_BASE[31:16] || int'(a[15:2]) >= SRAM_DEPTH)
            return -1;     // outside the SRAM
        return int'(a[15:2]);
    endfunction

    function automatic bit in_sysio(addr_t a);
        return a[31:12] == SYSIO_BASE[31:12];
    endfunction

    function automatic rd_exp_t expected_read(addr_t a);
        rd_exp_t e;
        int      idx;
        e.resp = RESP_OKAY;
        e.data = '0;
        idx    = sram_index(a);
        if (idx >= 0) begin
            e.data = sram_mdl[idx];
        end else if (in_sysio(a)) begin
            case (a[11:0])
                GPIO_OUT_OFS: e.data = out_mdl;
                GPIO_OE_OFS:  e.data = oe_mdl;
                GPIO_IN_OFS:  e.data = in_mdl;
                default:      e.data = '0;
            endcase
        end else begin
            e.resp = RESP_SLVERR;   // unmapped, data stays zero
        end
        return e;
    endfunction

    function automatic resp_t update_model(addr_t a, data_t d, strb_t s);
        int idx;
        idx = sram_index(a);
        if (idx >= 0) begin
            sram_mdl[idx]    = apply_strobes(sram_mdl[idx], d, s);
            was_written[idx] = 1'b1;
        end else if (in_sysio(a)) begin
            if (a[11:0] == GPIO_OUT_OFS)
                out_mdl = apply_strobes(out_mdl, d, s);
            else if (a[11:0] == GPIO_OE_OFS)
                oe_mdl = apply_strobes(oe_mdl, d, s);
        end else begin
            return RESP_SLVERR;
        end
        return RESP_OKAY;
    endfunction

    function automatic addr_t word_addr(int idx);
        return SRAM_BASE + (addr_t'(idx) << 2);
    endfunction

    function automatic addr_t io_addr(io_ofs_t o);
        return SYSIO_BASE | addr_t'(o);
    endfunction

    //******************************************************************
    // check bookkeeping
    function automatic void push_check(string what, data_t e, data_t a);
        name_q.push_back({cur_test, " ", what});
        exp_q.push_back(e);
        act_q.push_back(a);
    endfunction

    function automatic void check_wait(bit ok, string what);
        assert (ok) else begin
            $display("ERROR in %s: timed out waiting for %s", cur_test, what);
            n_errors++;
        end
    endfunction

    initial begin : compare
        string n;
        data_t e;
        data_t a;
        forever begin
            @(posedge clk);
            while (name_q.size() > 0) begin
                n = name_q.pop_front();
                e = exp_q.pop_front();
                a = act_q.pop_front();
                n_checks++;
                assert (e === a) else begin
                    $display("CHECK FAILED %s: expected %h, actual %h", n, e, a);
                    n_errors++;
                end
            end
        end
    end

    task automatic drain_checks();
        int t;
        t = 0;
        while (name_q.size() > 0 && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        check_wait(name_q.size() == 0, "the compare queue");
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_err0 = n_errors;
    endtask

    task automatic end_test();
        drain_checks();
        n_tests++;
        if (n_errors == test_err0) begin
            $display("test %s: passed", cur_test);
        end else begin
            $display("test %s: failed with %0d errors", cur_test, n_errors - test_err0);
            n_failed++;
        end
    endtask

    //******************************************************************
    // bus tasks, entered on a falling edge
    task automatic drive_req(input bit m, input axi_req_t r);
        if (m)
            m1_req = r;
        else
            m0_req = r;
    endtask

    function automatic axi_resp_t resp_of(bit m);
        return m ? m1_resp : m0_resp;
    endfunction

    function automatic void check_fair(bit m, int others);
        assert (done_cnt[!m] - others <= 1) else begin
            $display("ERROR in %s: master %0d waited for more than one other transaction",
                     cur_test, m);
            n_errors++;
        end
    endfunction

    task automatic axi_write(input bit m, input addr_t a, input data_t d, input strb_t s,
                             input int hold, output resp_t bresp);
        axi_req_t  r;
        axi_resp_t rs;
        int        t;
        int        others;
        r         = '0;
        r.awaddr  = a;
        r.awvalid = 1'b1;
        r.wdata   = d;
        r.wstrb   = s;
        r.wvalid  = 1'b1;
        others    = done_cnt[!m];
        drive_req(m, r);
        t = 0;
        do begin
            @(negedge clk);
            rs = resp_of(m);
            t++;
        end while (!(rs.awready && rs.wready) && t < TIMEOUT);
        check_wait(rs.awready && rs.wready, "awready and wready");
        acc_cyc[m] = cyc;
        @(negedge clk);                 // aw and w taken
        rs        = resp_of(m);
        r.awvalid = 1'b0;
        r.wvalid  = 1'b0;
        drive_req(m, r);
        t = 0;
        while (!rs.bvalid && t < TIMEOUT) begin
            @(negedge clk);
            rs = resp_of(m);
            t++;
        end
        check_wait(rs.bvalid, "bvalid");
        bresp = rs.bresp;
        repeat (hold) begin
            @(negedge clk);
            rs = resp_of(m);
            push_check("bvalid held", 32'd1, data_t'(rs.bvalid));
            push_check("bresp held", data_t'(bresp), data_t'(rs.bresp));
        end
        r.bready = 1'b1;
        drive_req(m, r);
        done_cyc[m] = cyc;
        @(negedge clk);
        r.bready = 1'b0;
        drive_req(m, r);
        done_cnt[m]++;
        check_fair(m, others);
    endtask

    task automatic axi_read(input bit m, input addr_t a, output data_t d, output resp_t rr);
        axi_req_t  r;
        axi_resp_t rs;
        int        t;
        int        others;
        r         = '0;
        r.araddr  = a;
        r.arvalid = 1'b1;
        others    = done_cnt[!m];
        drive_req(m, r);
        t = 0;
        do begin
            @(negedge clk);
            rs = resp_of(m);
            t++;
        end while (!rs.arready && t < TIMEOUT);
        check_wait(rs.arready, "arready");
        acc_cyc[m] = cyc;
        @(negedge clk);
        rs        = resp_of(m);
        r.arvalid = 1'b0;
        drive_req(m, r);
        t = 0;
        while (!rs.rvalid && t < TIMEOUT) begin
            @(negedge clk);
            rs = resp_of(m);
            t++;
        end
        check_wait(rs.rvalid, "rvalid");
        d  = rs.rdata;
        rr = rs.rresp;
        repeat ($urandom_range(2, 0)) @(negedge clk);   // rready held off
        r.rready = 1'b1;
        drive_req(m, r);
        done_cyc[m] = cyc;
        @(negedge clk);
        r.rready = 1'b0;
        drive_req(m, r);
        done_cnt[m]++;
        check_fair(m, others);
    endtask

    task automatic write_check(input bit m, input addr_t a, input data_t d, input strb_t s,
                               input int hold);
        resp_t got;
        resp_t exp;
        axi_write(m, a, d, s, hold, got);
        exp = update_model(a, d, s);
        push_check($sformatf("write %h bresp", a), data_t'(exp), data_t'(got));
    endtask

    task automatic read_check(input bit m, input addr_t a);
        data_t   got_d;
        resp_t   got_r;
        rd_exp_t e;
        axi_read(m, a, got_d, got_r);
        e = expected_read(a);
        push_check($sformatf("read %h rdata", a), e.data, got_d);
        push_check($sformatf("read %h rresp", a), data_t'(e.resp), data_t'(got_r));
    endtask

    task automatic random_op(input bit m, input int base);
        int    idx;
        strb_t s;
        idx = base + int'($urandom_range(15, 0));
        s   = was_written[idx] ? strb_t'($urandom_range(15, 1)) : 4'hf;  // fill word first
        if (!was_written[idx] || $urandom_range(1, 0) == 0)
            write_check(m, word_addr(idx), $urandom(), s, 0);
        else
            read_check(m, word_addr(idx));
    endtask

    task automatic set_gpio_in(input data_t v);
        gpio_i = v;
        in_mdl = v;
    endtask

    //******************************************************************
    // test sequence
    initial begin : main
        bit hm;
        rst_n   = 1'b0;
        m0_req  = '0;
        m1_req  = '0;
        gpio_i  = '0;
        out_mdl = '0;
        oe_mdl  = '0;
        in_mdl  = '0;
        void'($urandom(46539));
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        begin_test("reset_state");
        push_check("gpio_o", 32'd0, data_t'(gpio_o));
        push_check("gpio_oe", 32'd0, data_t'(gpio_oe));
        push_check("m0 valid", 32'd0, data_t'({m0_resp.bvalid, m0_resp.rvalid}));
        push_check("m1 valid", 32'd0, data_t'({m1_resp.bvalid, m1_resp.rvalid}));
        end_test();

        begin_test("sram_strobes");
        for (int i = 0; i < 48; i++)
            random_op(bit'(i % 2), 128);
        for (int i = 128; i < 144; i++) begin
            if (was_written[i])
                read_check(bit'(i % 2), word_addr(i));
        end
        end_test();

        begin_test("sysio_regs");
        write_check(1'b0, io_addr(GPIO_OUT_OFS), $urandom(), 4'hf, 0);
        push_check("gpio_o", out_mdl, data_t'(gpio_o));
        write_check(1'b1, io_addr(GPIO_OUT_OFS), $urandom(), 4'b0101, 0);
        push_check("gpio_o partial", out_mdl, data_t'(gpio_o));
        write_check(1'b1, io_addr(GPIO_OE_OFS), $urandom(), 4'hf, 0);
        write_check(1'b0, io_addr(GPIO_OE_OFS), $urandom(), 4'b1000, 0);
        push_check("gpio_oe", oe_mdl, data_t'(gpio_oe));
        read_check(1'b0, io_addr(GPIO_OUT_OFS));
        read_check(1'b1, io_addr(GPIO_OE_OFS));
        set_gpio_in($urandom());
        read_check(1'b0, io_addr(GPIO_IN_OFS));
        write_check(1'b1, io_addr(GPIO_IN_OFS), $urandom(), 4'hf, 0);   // read only
        read_check(1'b1, io_addr(GPIO_IN_OFS));
        read_check(1'b0, io_addr(12'h00c));
        end_test();

        begin_test("unmapped");
        write_check(1'b0, 32'h0000_0100, $urandom(), 4'hf, 0);
        read_check(1'b1, 32'h3000_0000);
        write_check(1'b1, word_addr(SRAM_DEPTH), $urandom(), 4'hf, 0);  // past the array
        read_check(1'b0, word_addr(SRAM_DEPTH));
        read_check(1'b0, 32'h2000_1000);
        end_test();

        begin_test("both_masters");
        fork
            for (int r = 0; r < 24; r++)
                random_op(1'b0, 0);
            for (int r = 0; r < 24; r++)
                random_op(1'b1, 64);
        join
        end_test();

        begin_test("back_pressure");
        write_check(1'b0, word_addr(300), $urandom(), 4'hf, 0);
        write_check(1'b1, word_addr(301), $urandom(), 4'hf, 0);
        for (int k = 0; k < 2; k++) begin
            hm = bit'(k);
            fork
                write_check(hm, word_addr(300), $urandom(), strb_t'($urandom_range(15, 1)),
                            2 + int'($urandom_range(6, 0)));
                begin
                    @(negedge clk);     // other master one cycle later
                    read_check(!hm, word_addr(301));
                end
            join
            assert (acc_cyc[!hm] > done_cyc[hm]) else begin
                $display("ERROR in %s: master %0d accepted while a response was held",
                         cur_test, !hm);
                n_errors++;
            end
        end
        read_check(1'b0, word_addr(300));
        end_test();

        drain_checks();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 n_tests, n_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
src/axi_pkg.sv
src/soc_pkg.sv
src/axi_arbiter.sv
src/axi_decoder.sv
src/sram.sv
src/sysio.sv
src/soc_top.sv
testbench/soc_sva.sv
testbench/soc_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module soc_tb -o soc_tb_sim -f vlog.f \
    > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/soc_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0
